// ==== mem_stage.f ====
logic/mem_pkg.sv
logic/refill_counter.sv
logic/dcache_ctrl.sv
logic/dcache_store.sv
logic/load_align.sv
logic/forward_unit.sv
logic/mem_stage_top.sv
sim/mem_stage_checker.sv
sim/mem_stage_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = mem_stage_tb
FILELIST = mem_stage.f
MDIR     = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)
	@out=$$(./$(MDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(MDIR)

// ==== sim/mem_stage_tb.sv ====
/*
 * memory stage testbench
 * clock and reset, random loads and stores, bus memory model, watchdog
 */
module mem_stage_tb
        import mem_pkg::*;
();

        localparam int period          = 10;
        localparam int reset_cycles    = 16;
        localparam int num_tests       = 600;
        localparam int max_delay       = 3;
        // address phase, every beat late, write done
        localparam int worst_op_cycles = 2 + (max_delay + 1) * (line_beats + 2);
        // idle draws can double the cycle count
        localparam int timeout = (reset_cycles + 2 * num_tests * worst_op_cycles) * period;
        localparam logic [xlen-1:0] window_base = 64'h0000_0000_8000_1000;

        logic clk, reset, mem_read, mem_write, unsigned_load, stall;
        mem_addr_t addr;
        size_t size;
        logic [xlen-1:0] wdata, rdata, araddr, bus_rdata, waddr, wdata_out;
        logic arvalid, arready, rvalid, rready, wvalid, wready;
        logic [strb_w-1:0] wstrb;
        logic [gpr_w-1:0] ex_rs1, ex_rs2, mem_rd, wb_rd;
        logic mem_write_gpr, mem_to_reg, wb_write_gpr, rs1_hazard, rs2_hazard;
        logic [xlen-1:0] mem_alu_out, wb_data, rs1_data, rs2_data;
        int error_count, check_count;

        integer seed = 32'hc0c3687d;
        logic [xlen-1:0] mem_model [logic [xlen-1:0]];
        logic [xlen-1:0] rd_base;
        logic ar_fire, r_fire, w_fire, op_done;
        int ar_cnt, r_cnt, w_cnt, beat_no, reset_count, issued, done_count;

        mem_stage_top u_mem_stage_top (.*);

        mem_stage_checker u_checker (.*);

        always #(period / 2) clk = ~clk;

        function automatic int draw(input int n);
                return int'($unsigned($random(seed)) % n);
        endfunction

        function automatic logic [xlen-1:0] rand64();
                logic [xlen-1:0] v;
                v[63:32] = $random(seed);
                v[31:0]  = $random(seed);
                return v;
        endfunction

        function automatic logic [xlen-1:0] read_mem(input logic [xlen-1:0] a);
                if (mem_model.exists(a)) begin
                        return mem_model[a];
                end
                // untouched memory holds a pattern of its own address
                return a ^ {a[31:0], a[63:32]} ^ 64'h9e37_79b9_7f4a_7c15;
        endfunction

        // ========================================
        // memory responder
        // ========================================
        task automatic respond_read();
                if (ar_fire) begin
                        arready = 1'b0;
                        rd_base = araddr;
                        beat_no = 0;
                        r_cnt   = draw(max_delay + 1);
                end else if (arvalid && !arready) begin
                        if (ar_cnt < 0) ar_cnt = draw(max_delay + 1);
                        if (ar_cnt == 0) arready = 1'b1;
                        ar_cnt--;
                end
                if (r_fire) begin
                        rvalid = 1'b0;
                        beat_no++;
                        r_cnt = (beat_no < line_beats) ? draw(max_delay + 1) : -1;
                end
                if (r_cnt == 0) begin
                        rvalid    = 1'b1;
                        bus_rdata = read_mem(rd_base + 64'(8 * beat_no));
                end
                if (r_cnt >= 0) r_cnt--;
        endtask

        task automatic respond_write();
                logic [xlen-1:0] word;
                if (w_fire) begin
                        wready = 1'b0;
                        word   = read_mem(waddr);
                        for (int i = 0; i < strb_w; i++) begin
                                if (wstrb[i]) word[8*i +: 8] = wdata_out[8*i +: 8];
                        end
                        mem_model[waddr] = word;
                end else if (wvalid && !wready) begin
                        if (w_cnt < 0) w_cnt = draw(max_delay + 1);
                        if (w_cnt == 0) wready = 1'b1;
                        w_cnt--;
                end
        endtask

        // ========================================
        // stimulus
        // ========================================
        task automatic draw_forwarding();
                ex_rs1        = gpr_w'(draw(4));
                ex_rs2        = gpr_w'(draw(4));
                mem_rd        = gpr_w'(draw(4));
                wb_rd         = gpr_w'(draw(4));
                mem_write_gpr = 1'(draw(2));
                mem_to_reg    = 1'(draw(2));
                wb_write_gpr  = 1'(draw(2));
                mem_alu_out   = rand64();
                wb_data       = rand64();
        endtask

        // three tags over four indexes, so lines conflict
        task automatic next_request();
                int kind;
                int sz;
                int tag_sel;
                int idx;
                int dw;
                int off;
                kind      = draw(10);
                mem_read  = 1'b0;
                mem_write = 1'b0;
                if (issued < num_tests && kind >= 2) begin
                        sz       = draw(4);
                        tag_sel  = draw(3);
                        idx      = draw(4);
                        dw       = draw(line_beats);
                        off      = draw(strb_w) & ~((1 << sz) - 1);
                        size     = size_t'(sz);
                        addr.raw = window_base + 64'(tag_sel * num_lines * line_beats * 8
                                                     + idx * line_beats * 8 + dw * 8 + off);
                        wdata         = rand64();
                        unsigned_load = 1'(draw(2));
                        mem_read      = (kind < 6);
                        mem_write     = (kind >= 6);
                        issued++;
                end
        endtask

        always @(negedge clk) begin
                ar_fire = arvalid && arready;
                r_fire  = rvalid && rready;
                w_fire  = wvalid && wready;
                op_done = !reset && (mem_read || mem_write) && !stall;
                if (op_done) done_count++;
        end

        always @(posedge clk) begin
                #1;
                if (reset_count < reset_cycles) begin
                        reset_count++;
                        if (reset_count == reset_cycles) reset = 1'b0;
                end else begin
                        respond_read();
                        respond_write();
                        draw_forwarding();
                        if (op_done || !(mem_read || mem_write)) next_request();
                end
        end

        initial begin
                clk = 1'b0;
                reset = 1'b1;
                {mem_read, mem_write, unsigned_load, arready, rvalid, wready} = '0;
                addr = '0;
                size = size_byte;
                wdata = '0;
                bus_rdata = '0;
                {ex_rs1, ex_rs2, mem_rd, wb_rd} = '0;
                {mem_write_gpr, mem_to_reg, wb_write_gpr} = '0;
                mem_alu_out = '0;
                wb_data = '0;
                {ar_fire, r_fire, w_fire, op_done} = '0;
                {ar_cnt, r_cnt, w_cnt} = {-32'sd1, -32'sd1, -32'sd1};
                {beat_no, reset_count, issued, done_count} = '0;
                wait (done_count == num_tests);
                repeat (2) @(posedge clk);
                $display("%0d operations, %0d checks, %0d errors", done_count, check_count,
                         error_count);
                if (error_count == 0) begin
                        $display("Test OK");
                end else begin
                        $display("Test FAILED");
                end
                $finish;
        end

        initial begin
                #(timeout);
                $display("watchdog expired with %0d of %0d operations finished",
                         done_count, num_tests);
                $display("Test FAILED");
                $finish;
        end

endmodule

// ==== sim/mem_stage_checker.sv ====
/*
 * memory stage checker
 * byte image of memory, expected load, bus and bypass values
 */
module mem_stage_checker
        import mem_pkg::*;
(
        input  logic              clk,
        input  logic              reset,
        input  logic              mem_read,
        input  logic              mem_write,
        input  mem_addr_t         addr,
        input  logic [xlen-1:0]   wdata,
        input  size_t             size,
        input  logic              unsigned_load,
        input  logic [xlen-1:0]   rdata,
        input  logic              stall,
        input  logic              arvalid, arready, rvalid, rready,
        input  logic [xlen-1:0]   araddr, bus_rdata,
        input  logic              wvalid, wready,
        input  logic [xlen-1:0]   waddr, wdata_out,
        input  logic [strb_w-1:0] wstrb,
        input  logic [gpr_w-1:0]  ex_rs1, ex_rs2, mem_rd, wb_rd,
        input  logic              mem_write_gpr, mem_to_reg, wb_write_gpr,
        input  logic [xlen-1:0]   mem_alu_out, wb_data,
        input  logic [xlen-1:0]   rs1_data, rs2_data,
        input  logic              rs1_hazard, rs2_hazard,
        output int                error_count,
        output int                check_count
);

        logic [7:0]      image [logic [xlen-1:0]];
        bit              line_seen [logic [xlen-1:0]];
        logic            read_issued;
        int              beat_count;
        logic [xlen-1:0] refill_base;

        initial begin
                error_count = 0;
                check_count = 0;
                read_issued = 1'b0;
                beat_count  = 0;
        end

        task automatic expect_value(input string name, input logic [xlen-1:0] got,
                                    input logic [xlen-1:0] exp);
                check_count++;
                if (got !== exp) begin
                        error_count++;
                        $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
                end
        endtask

        task automatic report(input string msg);
                error_count++;
                $display("ERROR at %0t: %s", $time, msg);
        endtask

        // ========================================
        // reference rules
        // ========================================
        // MEM wins over WB and x0 is never forwarded
        function automatic logic [xlen:0] expected_bypass(input logic [gpr_w-1:0] rs);
                if (rs == '0) begin
                        return '0;
                end
                if (mem_write_gpr && mem_rd == rs) begin
                        return {1'b1, mem_to_reg ? rdata : mem_alu_out};
                end
                if (wb_write_gpr && wb_rd == rs) begin
                        return {1'b1, wb_data};
                end
                return '0;
        endfunction

        task automatic check_forwarding();
                logic [xlen:0] exp1;
                logic [xlen:0] exp2;
                exp1 = expected_bypass(ex_rs1);
                exp2 = expected_bypass(ex_rs2);
                expect_value("rs1_hazard", 64'(rs1_hazard), 64'(exp1[xlen]));
                expect_value("rs1_data", rs1_data, exp1[xlen-1:0]);
                expect_value("rs2_hazard", 64'(rs2_hazard), 64'(exp2[xlen]));
                expect_value("rs2_data", rs2_data, exp2[xlen-1:0]);
        endtask

        task automatic check_bus_state();
                if ((arvalid || rready || wvalid) && !stall) begin
                        report("stall is low while a bus transfer is still open");
                end
                // with nothing requested the stage is quiet
                if (!mem_read && !mem_write) begin
                        expect_value("stall", 64'(stall), 64'd0);
                        expect_value("arvalid", 64'(arvalid), 64'd0);
                        expect_value("rready", 64'(rready), 64'd0);
                        expect_value("wvalid", 64'(wvalid), 64'd0);
                end
        endtask

        task automatic check_read_request();
                expect_value("araddr", araddr,
                             addr.raw - (addr.raw % 64'(line_beats * strb_w)));
                if (read_issued) begin
                        report("a second read request was issued for one load");
                end
                read_issued = 1'b1;
                beat_count  = 0;
                refill_base = araddr;
        endtask

        // memory contents become known as the bytes come back
        task automatic learn_beat();
                logic [xlen-1:0] a;
                if (!read_issued || beat_count >= line_beats) begin
                        report("refill beat accepted outside a line refill");
                end else begin
                        for (int i = 0; i < strb_w; i++) begin
                                a = refill_base + 64'(8 * beat_count + i);
                                if (!image.exists(a)) begin
                                        image[a] = bus_rdata[8*i +: 8];
                                end
                        end
                        beat_count++;
                end
        endtask

        task automatic check_write();
                logic [strb_w-1:0] exp_strb;
                logic [xlen-1:0]   exp_data;
                logic [xlen-1:0]   lane_mask;
                int                n;
                int                off;
                n         = 1 << size;
                off       = int'(addr.raw[off_w-1:0]);
                exp_strb  = '0;
                exp_data  = '0;
                lane_mask = '0;
                for (int i = 0; i < n; i++) begin
                        exp_strb[off + i]             = 1'b1;
                        exp_data[8*(off + i) +: 8]    = wdata[8*i +: 8];
                        lane_mask[8*(off + i) +: 8]   = 8'hff;
                        image[addr.raw + 64'(i)]      = wdata[8*i +: 8];
                end
                expect_value("waddr", waddr, addr.raw - (addr.raw % 64'(strb_w)));
                expect_value("wstrb", 64'(wstrb), 64'(exp_strb));
                expect_value("wdata_out", wdata_out & lane_mask, exp_data);
        endtask

        task automatic check_load();
                logic [xlen-1:0] exp;
                logic [xlen-1:0] line;
                logic            known;
                int              n;
                n     = 1 << size;
                exp   = '0;
                known = 1'b1;
                for (int i = 0; i < n; i++) begin
                        if (image.exists(addr.raw + 64'(i))) begin
                                exp[8*i +: 8] = image[addr.raw + 64'(i)];
                        end else begin
                                known = 1'b0;
                        end
                end
                if (!unsigned_load && n < strb_w && exp[8*n-1]) begin
                        exp = exp | (~64'h0 << (8 * n));
                end
                line = addr.raw >> line_off_w;
                if (!known) begin
                        report("load returned bytes that were never fetched or stored");
                end else begin
                        expect_value("rdata", rdata, exp);
                end
                if (!line_seen.exists(line) && !read_issued) begin
                        report("first load to a line finished without a read request");
                end
                if (read_issued && beat_count != line_beats) begin
                        report("load finished before a full line refill");
                end
                line_seen[line] = 1'b1;
                read_issued     = 1'b0;
        endtask

        task automatic check_store_done();
                if (read_issued) begin
                        report("a read request was issued for a store");
                end
                read_issued = 1'b0;
        endtask

        // ========================================
        // sampling at mid cycle
        // ========================================
        always @(negedge clk) begin
                if (!reset) begin
                        check_bus_state();
                        check_forwarding();
                        if (arvalid && arready) check_read_request();
                        if (rvalid && rready) learn_beat();
                        if (wvalid && wready) check_write();
                        if (mem_read && !stall) check_load();
                        if (mem_write && !stall) check_store_done();
                end
        end

endmodule

// ==== logic/mem_stage_top.sv ====
/*
 * memory stage top
 * data cache controller, refill counter, cache arrays, load alignment
 * and GPR forwarding for the execute stage
 */
module mem_stage_top
        import mem_pkg::*;
(
        input  logic               clk,
        input  logic               reset,
        // pipeline request
        input  logic               mem_read,
        input  logic               mem_write,
        input  mem_addr_t          addr,
        input  logic [xlen-1:0]    wdata,
        input  size_t              size,
        input  logic               unsigned_load,
        output logic [xlen-1:0]    rdata,
        output logic               stall,
        // read bus
        output logic               arvalid,
        input  logic               arready,
        output logic [xlen-1:0]    araddr,
        input  logic               rvalid,
        output logic               rready,
        input  logic [xlen-1:0]    bus_rdata,
        // write bus
        output logic               wvalid,
        input  logic               wready,
        output logic [xlen-1:0]    waddr,
        output logic [xlen-1:0]    wdata_out,
        output logic [strb_w-1:0]  wstrb,
        // forwarding
        input  logic [gpr_w-1:0]   ex_rs1,
        input  logic [gpr_w-1:0]   ex_rs2,
        input  logic [gpr_w-1:0]   mem_rd,
        input  logic               mem_write_gpr,
        input  logic               mem_to_reg,
        input  logic [xlen-1:0]    mem_alu_out,
        input  logic [gpr_w-1:0]   wb_rd,
        input  logic               wb_write_gpr,
        input  logic [xlen-1:0]    wb_data,
        output logic [xlen-1:0]    rs1_data,
        output logic [xlen-1:0]    rs2_data,
        output logic               rs1_hazard,
        output logic               rs2_hazard
);

        logic              hit;
        logic              last_beat;
        logic [beat_w-1:0] beat;
        logic              refill_we;
        logic              store_we;
        logic [xlen-1:0]   line_word;

        dcache_ctrl u_dcache_ctrl (
                .clk       (clk),       .reset     (reset),
                .mem_read  (mem_read),  .mem_write (mem_write),
                .addr      (addr),      .wdata     (wdata),
                .size      (size),      .hit       (hit),
                .arready   (arready),   .rvalid    (rvalid),
                .wready    (wready),    .last_beat (last_beat),
                .stall     (stall),     .arvalid   (arvalid),
                .araddr    (araddr),    .rready    (rready),
                .refill_we (refill_we), .store_we  (store_we),
                .wvalid    (wvalid),    .waddr     (waddr),
                .wdata_out (wdata_out), .wstrb     (wstrb)
        );

        // counter clears whenever the controller is out of refill
        refill_counter u_refill_counter (
                .clk       (clk),
                .reset     (reset),
                .clear     (~rready),
                .advance   (refill_we),
                .beat      (beat),
                .last_beat (last_beat)
        );

        dcache_store u_dcache_store (
                .clk       (clk),       .reset     (reset),
                .addr      (addr),      .beat      (beat),
                .refill_we (refill_we), .bus_rdata (bus_rdata),
                .store_we  (store_we),  .wdata_out (wdata_out),
                .wstrb     (wstrb),     .hit       (hit),
                .line_word (line_word)
        );

        load_align u_load_align (
                .line_word     (line_word),
                .byte_off      (addr.f.offset),
                .size          (size),
                .unsigned_load (unsigned_load),
                .load_data     (rdata)
        );

        forward_unit u_forward_unit (
                .ex_rs1        (ex_rs1),        .ex_rs2        (ex_rs2),
                .mem_rd        (mem_rd),        .mem_write_gpr (mem_write_gpr),
                .mem_to_reg    (mem_to_reg),    .mem_alu_out   (mem_alu_out),
                .load_data     (rdata),         .wb_rd         (wb_rd),
                .wb_write_gpr  (wb_write_gpr),  .wb_data       (wb_data),
                .rs1_data      (rs1_data),      .rs2_data      (rs2_data),
                .rs1_hazard    (rs1_hazard),    .rs2_hazard    (rs2_hazard)
        );

endmodule

// ==== logic/forward_unit.sv ====
/*
 * GPR forwarding
 * bypasses MEM or WB results to the execute operands, MEM first
 */
module forward_unit
        import mem_pkg::*;
(
        input  logic [gpr_w-1:0] ex_rs1,
        input  logic [gpr_w-1:0] ex_rs2,
        input  logic [gpr_w-1:0] mem_rd,
        input  logic             mem_write_gpr,
        input  logic             mem_to_reg,
        input  logic [xlen-1:0]  mem_alu_out,
        input  logic [xlen-1:0]  load_data,
        input  logic [gpr_w-1:0] wb_rd,
        input  logic             wb_write_gpr,
        input  logic [xlen-1:0]  wb_data,
        output logic [xlen-1:0]  rs1_data,
        output logic [xlen-1:0]  rs2_data,
        output logic             rs1_hazard,
        output logic             rs2_hazard
);

        logic [xlen-1:0] mem_result;

        // loads in MEM forward the aligned cache data
        assign mem_result = mem_to_reg ? load_data : mem_alu_out;

        // {hazard, data}, all zero when nothing matches
        function automatic logic [xlen:0] bypass(
                input logic [gpr_w-1:0] rs,
                input logic [xlen-1:0]  mem_val,
                input logic [xlen-1:0]  wb_val
        );
                logic [xlen:0] r;
                r = '0;
                if (rs != '0 && mem_write_gpr && rs == mem_rd) begin
                        r = {1'b1, mem_val};
                end else if (rs != '0 && wb_write_gpr && rs == wb_rd) begin
                        r = {1'b1, wb_val};
                end
                return r;
        endfunction

        always_comb begin
                {rs1_hazard, rs1_data} = bypass(ex_rs1, mem_result, wb_data);
                {rs2_hazard, rs2_data} = bypass(ex_rs2, mem_result, wb_data);
        end

endmodule

// ==== logic/load_align.sv ====
/*
 * load data alignment
 * moves the addressed bytes down to bit zero and extends them
 */
module load_align
        import mem_pkg::*;
(
        input  logic [xlen-1:0]  line_word,
        input  logic [off_w-1:0] byte_off,
        input  size_t            size,
        input  logic             unsigned_load,
        output logic [xlen-1:0]  load_data
);

        logic [xlen-1:0] shifted;
        logic            sign_bit;

        assign shifted = line_word >> {byte_off, 3'b000};

        always_comb begin
                case (size)
                size_byte: begin
                        sign_bit  = shifted[7] && !unsigned_load;
                        load_data = {{(xlen - 8){sign_bit}}, shifted[7:0]};
                end
                size_half: begin
                        sign_bit  = shifted[15] && !unsigned_load;
                        load_data = {{(xlen - 16){sign_bit}}, shifted[15:0]};
                end
                size_word: begin
                        sign_bit  = shifted[31] && !unsigned_load;
                        load_data = {{(xlen - 32){sign_bit}}, shifted[31:0]};
                end
                default: begin
                        // full double word, nothing to extend
                        sign_bit  = 1'b0;
                        load_data = shifted;
                end
                endcase
        end

endmodule

// ==== logic/dcache_store.sv ====
/*
 * data cache arrays
 * direct-mapped tag, valid and data storage with refill writes,
 * store-hit byte merge and combinational lookup
 */
module dcache_store
        import mem_pkg::*;
(
        input  logic               clk,
        input  logic               reset,
        input  mem_addr_t          addr,
        input  logic [beat_w-1:0]  beat,
        input  logic               refill_we,
        input  logic [xlen-1:0]    bus_rdata,
        input  logic               store_we,
        input  logic [xlen-1:0]    wdata_out,
        input  logic [strb_w-1:0]  wstrb,
        output logic               hit,
        output logic [xlen-1:0]    line_word
);

        logic [xlen-1:0]      data_q [num_lines][line_beats];
        logic [tag_w-1:0]     tag_q [num_lines];
        logic [num_lines-1:0] valid_q;
        logic                 refill_last;
        logic [xlen-1:0]      merged_word;

        assign refill_last = (beat == beat_w'(line_beats - 1));

        // ========================================
        // valid bits
        // ========================================
        // line is invalid while its beats are being replaced
        always_ff @(posedge clk) begin
                if (reset) begin
                        valid_q <= '0;
                end else if (refill_we) begin
                        valid_q[addr.f.index] <= refill_last;
                end
        end

        // ========================================
        // tag and data arrays
        // ========================================
        always_comb begin
                merged_word = line_word;
                for (int i = 0; i < strb_w; i++) begin
                        if (wstrb[i]) begin
                                merged_word[8*i +: 8] = wdata_out[8*i +: 8];
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (refill_we) begin
                        data_q[addr.f.index][beat] <= bus_rdata;
                        if (refill_last) begin
                                tag_q[addr.f.index] <= addr.f.tag;
                        end
                end
                if (store_we) begin
                        data_q[addr.f.index][addr.f.beat] <= merged_word;
                end
        end

        // lookup
        assign hit       = valid_q[addr.f.index] && (tag_q[addr.f.index] == addr.f.tag);
        assign line_word = data_q[addr.f.index][addr.f.beat];

endmodule

// ==== logic/dcache_ctrl.sv ====
/*
 * data cache controller
 * line refill on a load miss, write-through of every store,
 * stall generation and write strobe / lane placement
 */
module dcache_ctrl
        import mem_pkg::*;
(
        input  logic               clk,
        input  logic               reset,
        input  logic               mem_read,
        input  logic               mem_write,
        input  mem_addr_t          addr,
        input  logic [xlen-1:0]    wdata,
        input  size_t              size,
        input  logic               hit,
        input  logic               arready,
        input  logic               rvalid,
        input  logic               wready,
        input  logic               last_beat,
        output logic               stall,
        output logic               arvalid,
        output logic [xlen-1:0]    araddr,
        output logic               rready,
        output logic               refill_we,
        output logic               store_we,
        output logic               wvalid,
        output logic [xlen-1:0]    waddr,
        output logic [xlen-1:0]    wdata_out,
        output logic [strb_w-1:0]  wstrb
);

        logic [state_w-1:0] state_q;
        logic [state_w-1:0] state_d;
        logic [off_w-1:0]   byte_off;
        logic [strb_w-1:0]  size_mask;

        // ========================================
        // state machine
        // ========================================
        always_ff @(posedge clk) begin
                if (reset) begin
                        state_q <= st_idle;
                end else begin
                        state_q <= state_d;
                end
        end

        always_comb begin
                state_d = state_q;
                case (state_q)
                st_idle: begin
                        if (mem_write) begin
                                state_d = st_write;
                        end else if (mem_read && !hit) begin
                                state_d = st_rd_req;
                        end
                end
                st_rd_req:     if (arready) state_d = st_refill;
                st_refill:     if (rvalid && last_beat) state_d = st_idle;
                st_write:      if (wready) state_d = st_write_done;
                st_write_done: state_d = st_idle;
                default:       state_d = st_idle;
                endcase
        end

        // low only for a hit in idle and the cycle after a write handshake
        assign stall = (state_q == st_idle) ? (mem_write || (mem_read && !hit))
                                            : (state_q != st_write_done);

        assign arvalid   = (state_q == st_rd_req);
        assign rready    = (state_q == st_refill);
        assign refill_we = rready && rvalid;
        assign wvalid    = (state_q == st_write);
        // write-through; the cached copy only follows on a hit
        assign store_we  = wvalid && wready && hit;

        // ========================================
        // bus addresses and write lanes
        // ========================================
        assign byte_off = addr.raw[off_w-1:0];
        assign araddr   = {addr.raw[xlen-1:line_off_w], {line_off_w{1'b0}}};
        assign waddr    = {addr.raw[xlen-1:off_w], {off_w{1'b0}}};

        always_comb begin
                case (size)
                size_byte: size_mask = 8'h01;
                size_half: size_mask = 8'h03;
                size_word: size_mask = 8'h0f;
                default:   size_mask = 8'hff;
                endcase
        end

        assign wstrb     = size_mask << byte_off;
        assign wdata_out = wdata << {byte_off, 3'b000};

endmodule

// ==== logic/refill_counter.sv ====
/*
 * refill beat counter
 * counts accepted line beats and flags the final one
 */
module refill_counter
        import mem_pkg::*;
(
        input  logic              clk,
        input  logic              reset,
        input  logic              clear,
        input  logic              advance,
        output logic [beat_w-1:0] beat,
        output logic              last_beat
);

        // wraps back to zero after the final beat
        always_ff @(posedge clk) begin
                if (reset || clear) begin
                        beat <= '0;
                end else if (advance) begin
                        beat <= beat + 1'b1;
                end
        end

        assign last_beat = (beat == beat_w'(line_beats - 1));

endmodule

// ==== logic/mem_pkg.sv ====
/*
 * memory stage package
 * widths, data cache geometry, access size codes, controller states
 * and the address word shared by the controller and the cache arrays
 */
package mem_pkg;

        localparam int xlen       = 64;
        localparam int gpr_w      = 5;
        localparam int strb_w     = xlen / 8;

        // cache geometry
        localparam int line_beats = 4;
        localparam int beat_w     = 2;
        localparam int index_w    = 4;
        localparam int num_lines  = 1 << index_w;
        localparam int off_w      = 3;
        localparam int line_off_w = beat_w + off_w;
        localparam int tag_w      = xlen - index_w - line_off_w;

        typedef logic [1:0] size_t;

        localparam size_t size_byte  = 2'd0;
        localparam size_t size_half  = 2'd1;
        localparam size_t size_word  = 2'd2;
        localparam size_t size_dword = 2'd3;

        // cache controller states
        localparam int state_w = 3;
        localparam logic [state_w-1:0] st_idle       = 3'd0;
        localparam logic [state_w-1:0] st_rd_req     = 3'd1;
        localparam logic [state_w-1:0] st_refill     = 3'd2;
        localparam logic [state_w-1:0] st_write      = 3'd3;
        localparam logic [state_w-1:0] st_write_done = 3'd4;

        // one address word, seen raw by the bus and by field by the arrays
        typedef union packed {
                logic [xlen-1:0] raw;
                struct packed {
                        logic [tag_w-1:0]   tag;
                        logic [index_w-1:0] index;
                        logic [beat_w-1:0]  beat;
                        logic [off_w-1:0]   offset;
                } f;
        } mem_addr_t;

endpackage
